/* Makefile */
# Verilator build and run for the operand request stage

VERILATOR ?= verilator
TOP       ?= operand_request_stage_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?=

FAIL_MSG := Simulation finished: FAIL
PASS_MSG := Simulation finished: PASS
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run incomplete, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/bank_arbiter.sv */
`timescale 1ns/1ps

module bank_arbiter #(
  parameter int unsigned NrBanks = 4
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         alu_req_i,
  input  vrf_pkg::vrf_req_t                            alu_i,
  input  logic              [vrf_pkg::NrReaders-1:0]   rd_req_i,
  input  vrf_pkg::vrf_req_t [vrf_pkg::NrReaders-1:0]   rd_i,
  input  logic                                         ldu_req_i,
  input  vrf_pkg::vrf_req_t                            ldu_i,
  output logic                                         alu_gnt_o,
  output logic              [vrf_pkg::NrReaders-1:0]   rd_gnt_o,
  output logic                                         ldu_gnt_o,
  output logic                                         vrf_req_o,
  output vrf_pkg::vrf_req_t                            vrf_o
);

  localparam int unsigned BankBits = $clog2(NrBanks);
  localparam int unsigned RrWidth  = (vrf_pkg::NrReaders > 1) ? $clog2(vrf_pkg::NrReaders) : 1;

  logic [RrWidth-1:0] rr_q, rr_d;
  logic               rd_any;

  //////////////////////////////////////////////////
  // Priority and round robin
  //////////////////////////////////////////////////

  assign rd_any    = |rd_req_i;
  assign alu_gnt_o = alu_req_i;
  assign ldu_gnt_o = ldu_req_i && !alu_req_i && !rd_any;
  assign vrf_req_o = alu_req_i || rd_any || ldu_req_i;

  always_comb begin
    logic [RrWidth-1:0] idx;
    logic               found;
    rd_gnt_o = '0;
    rr_d     = rr_q;
    found    = 1'b0;
    idx      = '0;
    vrf_o    = ldu_i;
    if (alu_req_i) begin
      vrf_o = alu_i;
    end else begin
      // Search starts at the pointer and wraps around
      for (int i = 0; i < vrf_pkg::NrReaders; i++) begin
        idx = RrWidth'((int'(rr_q) + i) % vrf_pkg::NrReaders);
        if (!found && rd_req_i[idx]) begin
          found         = 1'b1;
          rd_gnt_o[idx] = 1'b1;
          vrf_o         = rd_i[idx];
          rr_d          = RrWidth'((int'(idx) + 1) % vrf_pkg::NrReaders);
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else begin
      rr_q <= rr_d;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_onehot_gnt : assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot0({alu_gnt_o, rd_gnt_o, ldu_gnt_o})
  ) else $error("bank arbiter granted more than one master");

  // Payload builders must hand over a row, not a word address
  a_row_in_range : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    vrf_req_o |-> vrf_o.addr[vrf_pkg::VaddrWidth-1 -: BankBits] == '0
  ) else $error("bank access row is out of range");

endmodule

/* logic/element_counter.sv */
`timescale 1ns/1ps

module element_counter #(
  parameter int unsigned NrBanks = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      load_i,
  input  vrf_pkg::operand_request_t cmd_i,
  input  logic                      step_i,
  output vrf_pkg::vaddr_t           addr_o,
  output logic                      done_o
);

  vrf_pkg::vaddr_t addr_q;
  vrf_pkg::vl_t    len_q;
  vrf_pkg::vew_e   vew_q;
  vrf_pkg::vl_t    elems_per_word;

  // The bank select bits of addr_o only work for these bank counts
  if (NrBanks < 2 || NrBanks > 8 || (NrBanks & (NrBanks - 1)) != 0) begin : gen_bank_check
    $error("NrBanks must be a power of two from 2 to 8");
  end

  assign elems_per_word = vrf_pkg::vl_t'(vrf_pkg::ElenBytes >> unsigned'(vew_q));
  assign addr_o         = addr_q;
  assign done_o         = step_i && (len_q <= elems_per_word);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
      len_q  <= '0;
      vew_q  <= vrf_pkg::EW64;
    end else if (load_i) begin
      addr_q <= cmd_i.addr;
      vew_q  <= cmd_i.eew;
      // An empty vector still reads one word
      len_q  <= (cmd_i.vl == '0) ? vrf_pkg::vl_t'(1) : cmd_i.vl;
    end else if (step_i) begin
      addr_q <= addr_q + 1'b1;
      len_q  <= (len_q > elems_per_word) ? len_q - elems_per_word : '0;
    end
  end

  // The requester must stop once the last word was granted
  a_no_step_when_empty : assert property (
    @(posedge clk_i) disable iff (!rst_ni) step_i |-> len_q != '0
  ) else $error("element_counter stepped with no elements left");

endmodule

/* logic/operand_request_stage.sv */
`timescale 1ns/1ps

module operand_request_stage #(
  parameter int unsigned NrBanks = 4
) (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  vrf_pkg::operand_request_t [vrf_pkg::NrReaders-1:0]    operand_request_i,
  input  logic                      [vrf_pkg::NrReaders-1:0]    operand_request_valid_i,
  output logic                      [vrf_pkg::NrReaders-1:0]    operand_request_ready_o,
  input  logic                      [vrf_pkg::NrReaders-1:0]    operand_queue_ready_i,
  output logic                      [vrf_pkg::NrReaders-1:0]    operand_issued_o,
  input  vrf_pkg::result_t                                      alu_result_i,
  input  logic                                                  alu_result_req_i,
  output logic                                                  alu_result_gnt_o,
  input  vrf_pkg::result_t                                      ldu_result_i,
  input  logic                                                  ldu_result_req_i,
  output logic                                                  ldu_result_gnt_o,
  output logic                                                  ldu_result_final_gnt_o,
  output logic                      [NrBanks-1:0]               vrf_req_o,
  output vrf_pkg::vrf_req_t         [NrBanks-1:0]               vrf_o
);

  localparam int unsigned BankBits = $clog2(NrBanks);

  // Reader side, indexed by reader then bank
  logic              [vrf_pkg::NrReaders-1:0][NrBanks-1:0] rd_bank_req;
  logic              [vrf_pkg::NrReaders-1:0][NrBanks-1:0] rd_bank_gnt;
  vrf_pkg::vrf_req_t [vrf_pkg::NrReaders-1:0]              rd_payload;

  // Bank side, indexed by bank then reader
  logic [NrBanks-1:0][vrf_pkg::NrReaders-1:0] bank_rd_req;
  logic [NrBanks-1:0][vrf_pkg::NrReaders-1:0] bank_rd_gnt;

  logic [NrBanks-1:0] alu_bank_req;
  logic [NrBanks-1:0] alu_bank_gnt;
  logic [NrBanks-1:0] ldu_bank_req;
  logic [NrBanks-1:0] ldu_bank_gnt;

  vrf_pkg::result_t  ldu_result;
  logic              ldu_req;
  logic              ldu_gnt;
  vrf_pkg::vrf_req_t alu_payload;
  vrf_pkg::vrf_req_t ldu_payload;

  //////////////////////////////////////////////////
  // Read requesters
  //////////////////////////////////////////////////

  for (genvar r = 0; r < vrf_pkg::NrReaders; r++) begin : gen_requesters
    operand_requester_fsm #(
      .NrBanks (NrBanks),
      .QueueId (vrf_pkg::opqueue_e'(1'(r)))
    ) i_requester (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .cmd_i         (operand_request_i[r]),
      .cmd_valid_i   (operand_request_valid_i[r]),
      .cmd_ready_o   (operand_request_ready_o[r]),
      .queue_ready_i (operand_queue_ready_i[r]),
      .bank_gnt_i    (rd_bank_gnt[r]),
      .bank_req_o    (rd_bank_req[r]),
      .vrf_o         (rd_payload[r]),
      .issued_o      (operand_issued_o[r])
    );
  end

  //////////////////////////////////////////////////
  // Write-back ports
  //////////////////////////////////////////////////

  result_stream_reg i_ldu_stream_reg (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .result_i    (ldu_result_i),
    .req_i       (ldu_result_req_i),
    .gnt_o       (ldu_result_gnt_o),
    .result_o    (ldu_result),
    .req_o       (ldu_req),
    .gnt_i       (ldu_gnt),
    .final_gnt_o (ldu_result_final_gnt_o)
  );

  assign alu_payload = '{
    addr    : alu_result_i.addr >> BankBits,
    wen     : 1'b1,
    wdata   : alu_result_i.wdata,
    be      : alu_result_i.be,
    opqueue : vrf_pkg::ALU_A
  };

  assign ldu_payload = '{
    addr    : ldu_result.addr >> BankBits,
    wen     : 1'b1,
    wdata   : ldu_result.wdata,
    be      : ldu_result.be,
    opqueue : vrf_pkg::ALU_A
  };

  assign alu_result_gnt_o = |alu_bank_gnt;
  assign ldu_gnt          = |ldu_bank_gnt;

  //////////////////////////////////////////////////
  // Bank arbiters
  //////////////////////////////////////////////////

  for (genvar b = 0; b < NrBanks; b++) begin : gen_banks
    assign alu_bank_req[b] = alu_result_req_i &&
                             (alu_result_i.addr[BankBits-1:0] == BankBits'(b));
    assign ldu_bank_req[b] = ldu_req && (ldu_result.addr[BankBits-1:0] == BankBits'(b));

    for (genvar r = 0; r < vrf_pkg::NrReaders; r++) begin : gen_transpose
      assign bank_rd_req[b][r] = rd_bank_req[r][b];
      assign rd_bank_gnt[r][b] = bank_rd_gnt[b][r];
    end

    bank_arbiter #(
      .NrBanks (NrBanks)
    ) i_bank_arbiter (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .alu_req_i (alu_bank_req[b]),
      .alu_i     (alu_payload),
      .rd_req_i  (bank_rd_req[b]),
      .rd_i      (rd_payload),
      .ldu_req_i (ldu_bank_req[b]),
      .ldu_i     (ldu_payload),
      .alu_gnt_o (alu_bank_gnt[b]),
      .rd_gnt_o  (bank_rd_gnt[b]),
      .ldu_gnt_o (ldu_bank_gnt[b]),
      .vrf_req_o (vrf_req_o[b]),
      .vrf_o     (vrf_o[b])
    );
  end

endmodule

/* logic/operand_requester_fsm.sv */
`timescale 1ns/1ps

module operand_requester_fsm #(
  parameter int unsigned       NrBanks = 4,
  parameter vrf_pkg::opqueue_e QueueId = vrf_pkg::ALU_A
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  vrf_pkg::operand_request_t cmd_i,
  input  logic                      cmd_valid_i,
  output logic                      cmd_ready_o,
  input  logic                      queue_ready_i,
  input  logic [NrBanks-1:0]        bank_gnt_i,
  output logic [NrBanks-1:0]        bank_req_o,
  output vrf_pkg::vrf_req_t         vrf_o,
  output logic                      issued_o
);

  localparam int unsigned BankBits = $clog2(NrBanks);

  vrf_pkg::req_state_e state_q, state_d;
  vrf_pkg::vaddr_t     addr;
  logic [BankBits-1:0] bank;
  logic                active;
  logic                granted;
  logic                done;
  logic                accept;

  element_counter #(
    .NrBanks (NrBanks)
  ) i_element_counter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .load_i (accept),
    .cmd_i  (cmd_i),
    .step_i (granted),
    .addr_o (addr),
    .done_o (done)
  );

  // Low address bits pick the bank
  assign bank   = addr[BankBits-1:0];
  assign active = (state_q == vrf_pkg::REQUESTING) && queue_ready_i;

  always_comb begin
    bank_req_o = '0;
    if (active) begin
      bank_req_o[bank] = 1'b1;
    end
  end

  assign granted  = |bank_gnt_i;
  assign issued_o = granted;

  // Take a new command when idle or right on the last grant
  assign accept      = cmd_valid_i && (state_q == vrf_pkg::IDLE || (granted && done));
  assign cmd_ready_o = accept;

  assign vrf_o = '{
    addr    : addr >> BankBits,
    wen     : 1'b0,
    wdata   : '0,
    be      : '0,
    opqueue : QueueId
  };

  always_comb begin
    state_d = state_q;
    if (accept) begin
      // A zero vl is acknowledged without any reads
      state_d = (cmd_i.vl != '0) ? vrf_pkg::REQUESTING : vrf_pkg::IDLE;
    end else if (granted && done) begin
      state_d = vrf_pkg::IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= vrf_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Bank arbiters only grant a reader that is requesting
  a_no_issue_in_idle : assert property (
    @(posedge clk_i) disable iff (!rst_ni) issued_o |-> state_q == vrf_pkg::REQUESTING
  ) else $error("operand issued while requester is idle");

endmodule

/* logic/result_stream_reg.sv */
`timescale 1ns/1ps

module result_stream_reg (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  vrf_pkg::result_t result_i,
  input  logic             req_i,
  output logic             gnt_o,
  output vrf_pkg::result_t result_o,
  output logic             req_o,
  input  logic             gnt_i,
  output logic             final_gnt_o
);

  logic             valid_q;
  vrf_pkg::result_t data_q;

  // Accept when empty or when the entry leaves this cycle, never in reset
  assign gnt_o    = rst_ni && (!valid_q || gnt_i);
  assign req_o    = valid_q;
  assign result_o = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q     <= 1'b0;
      final_gnt_o <= 1'b0;
    end else begin
      if (req_i && gnt_o) begin
        valid_q <= 1'b1;
      end else if (gnt_i) begin
        valid_q <= 1'b0;
      end
      // Final grant follows the actual VRF write by one cycle
      final_gnt_o <= gnt_i && valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && gnt_o) begin
      data_q <= result_i;
    end
  end

  a_hold_while_waiting : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_o && !gnt_i |=> req_o && $stable(result_o)
  ) else $error("load result changed while waiting for the VRF");

endmodule

/* logic/vrf_pkg.sv */
package vrf_pkg;

  // Datapath widths
  localparam int unsigned ElenBits   = 64;
  localparam int unsigned ElenBytes  = ElenBits / 8;
  localparam int unsigned VaddrWidth = 12;
  localparam int unsigned VlWidth    = 10;

  // One requester per ALU operand queue
  localparam int unsigned NrReaders = 2;

  typedef logic [ElenBits-1:0]   elen_t;
  typedef logic [ElenBytes-1:0]  strb_t;
  typedef logic [VaddrWidth-1:0] vaddr_t;
  typedef logic [VlWidth-1:0]    vl_t;

  // A word holds 8, 4, 2 or 1 elements
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  typedef enum logic {
    ALU_A,
    ALU_B
  } opqueue_e;

  typedef enum logic {
    IDLE,
    REQUESTING
  } req_state_e;

  // Read command for one requester
  typedef struct packed {
    vaddr_t addr;
    vl_t    vl;
    vew_e   eew;
  } operand_request_t;

  // Write request from a functional unit, addr is a word address
  typedef struct packed {
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } result_t;

  // One bank access, addr is the row inside the bank
  typedef struct packed {
    vaddr_t   addr;
    logic     wen;
    elen_t    wdata;
    strb_t    be;
    opqueue_e opqueue;
  } vrf_req_t;

endpackage

/* verification/operand_request_stage_tb.sv */
`timescale 1ns/1ps

module operand_request_stage_tb;

  localparam int unsigned NrBanks     = 4;
  localparam int unsigned BankBits    = $clog2(NrBanks);
  localparam int unsigned NrRd        = vrf_pkg::NrReaders;
  localparam int unsigned ClkPeriodNs = 4;
  localparam int unsigned NumCmds     = 20;
  localparam int unsigned MaxVl       = 48;
  localparam int unsigned NumWrites   = 40;
  // Each read word may lose cycles to back-pressure, writes and contention
  localparam int unsigned TimeoutCycles = NumCmds * (MaxVl + 4) * 8 + 2000;

  logic clk_i = 1'b0;
  logic rst_ni;

  vrf_pkg::operand_request_t [NrRd-1:0] operand_request;
  logic [NrRd-1:0] operand_request_valid;
  logic [NrRd-1:0] operand_request_ready;
  logic [NrRd-1:0] operand_queue_ready;
  logic [NrRd-1:0] operand_issued;
  vrf_pkg::result_t alu_result;
  logic             alu_result_req;
  logic             alu_result_gnt;
  vrf_pkg::result_t ldu_result;
  logic             ldu_result_req;
  logic             ldu_result_gnt;
  logic             ldu_result_final_gnt;
  logic              [NrBanks-1:0] vrf_req;
  vrf_pkg::vrf_req_t [NrBanks-1:0] vrf;

  // Reference model state
  vrf_pkg::vaddr_t     exp_addr [NrRd];
  int unsigned         exp_left [NrRd];
  logic [NrBanks-1:0]  rr_next;
  vrf_pkg::result_t    ldu_pending [$];
  logic                ldu_wrote;
  int unsigned         mismatches = 0;
  int unsigned         failures = 0;

  logic [NrRd-1:0]     rd_active;
  logic [BankBits-1:0] rd_bank [NrRd];
  vrf_pkg::vaddr_t     rd_row_seen [NrRd];
  logic [BankBits-1:0] alu_bank;
  vrf_pkg::vrf_req_t   alu_seen;
  logic                contend;

  always #(ClkPeriodNs / 2) clk_i = ~clk_i;

  operand_request_stage #(
    .NrBanks (NrBanks)
  ) operand_request_stage_inst (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .operand_request_i       (operand_request),
    .operand_request_valid_i (operand_request_valid),
    .operand_request_ready_o (operand_request_ready),
    .operand_queue_ready_i   (operand_queue_ready),
    .operand_issued_o        (operand_issued),
    .alu_result_i            (alu_result),
    .alu_result_req_i        (alu_result_req),
    .alu_result_gnt_o        (alu_result_gnt),
    .ldu_result_i            (ldu_result),
    .ldu_result_req_i        (ldu_result_req),
    .ldu_result_gnt_o        (ldu_result_gnt),
    .ldu_result_final_gnt_o  (ldu_result_final_gnt),
    .vrf_req_o               (vrf_req),
    .vrf_o                   (vrf)
  );

  //////////////////////////////////////////////////
  // Error logging
  //////////////////////////////////////////////////

  task automatic log_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
    mismatches++;
    $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
  endtask

  task automatic log_failure(string what);
    failures++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Words read for vl elements of 2^eew bytes each
  function automatic int unsigned word_count(vrf_pkg::vl_t vl, vrf_pkg::vew_e eew);
    int unsigned bytes;
    bytes = int'(vl) * (32'd1 << eew);
    return (bytes + 7) / 8;
  endfunction

  for (genvar r = 0; r < NrRd; r++) begin : gen_rd_view
    assign rd_bank[r]     = exp_addr[r][BankBits-1:0];
    assign rd_active[r]   = (exp_left[r] != 0) && operand_queue_ready[r];
    assign rd_row_seen[r] = vrf[rd_bank[r]].addr;
  end

  assign alu_bank = alu_result.addr[BankBits-1:0];
  assign alu_seen = vrf[alu_bank];
  assign contend  = (&rd_active) && (rd_bank[0] == rd_bank[1]) &&
                    !(alu_result_req && alu_bank == rd_bank[0]);

  task automatic check_load_write(int unsigned b);
    vrf_pkg::result_t exp;
    if (ldu_pending.size() == 0) begin
      log_failure($sformatf("VRF write on bank %0d with no load result pending", b));
    end else begin
      exp = ldu_pending.pop_front();
      assert (exp.addr[BankBits-1:0] == BankBits'(b))
        else log_mismatch("load write bank", 64'(exp.addr[BankBits-1:0]), 64'(b));
      assert (vrf[b].addr == (exp.addr >> BankBits))
        else log_mismatch("vrf_o.addr", 64'(exp.addr >> BankBits), 64'(vrf[b].addr));
      assert (vrf[b].wdata == exp.wdata)
        else log_mismatch("vrf_o.wdata", exp.wdata, vrf[b].wdata);
      assert (vrf[b].be == exp.be)
        else log_mismatch("vrf_o.be", 64'(exp.be), 64'(vrf[b].be));
    end
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    logic wrote;
    if (!rst_ni) begin
      for (int r = 0; r < NrRd; r++) begin
        exp_left[r] <= 0;
        exp_addr[r] <= '0;
      end
      rr_next   <= '0;
      ldu_wrote <= 1'b0;
    end else begin
      for (int r = 0; r < NrRd; r++) begin
        if (operand_request_valid[r] && operand_request_ready[r]) begin
          exp_left[r] <= word_count(operand_request[r].vl, operand_request[r].eew);
          exp_addr[r] <= operand_request[r].addr;
        end else if (operand_issued[r]) begin
          exp_left[r] <= exp_left[r] - 1;
          exp_addr[r] <= exp_addr[r] + 1'b1;
        end
        // Pointer moves to the reader after the one granted
        if (operand_issued[r]) begin
          rr_next[rd_bank[r]] <= (r == 0);
        end
      end
      // Writes not owned by the ALU come from the load path
      wrote = 1'b0;
      for (int b = 0; b < NrBanks; b++) begin
        if (vrf_req[b] && vrf[b].wen && !(alu_result_req && alu_bank == BankBits'(b))) begin
          wrote = 1'b1;
          check_load_write(b);
        end
      end
      ldu_wrote <= wrote;
      // A load is taken when none is held or the held one is written now
      assert (ldu_result_gnt == (ldu_pending.size() == 0))
        else log_mismatch("ldu_result_gnt_o", 64'(ldu_pending.size() == 0),
          64'(ldu_result_gnt));
      if (ldu_result_req && ldu_result_gnt) begin
        ldu_pending.push_back(ldu_result);
      end
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  for (genvar r = 0; r < NrRd; r++) begin : gen_rd_checks
    a_ready : assert property (@(posedge clk_i) disable iff (!rst_ni)
      operand_request_ready[r] == (operand_request_valid[r] &&
        (exp_left[r] == 0 || (exp_left[r] == 1 && operand_issued[r]))))
      else log_mismatch($sformatf("operand_request_ready_o[%0d]", r),
        64'(!$sampled(operand_request_ready[r])), 64'($sampled(operand_request_ready[r])));

    a_word_count : assert property (@(posedge clk_i) disable iff (!rst_ni)
      operand_issued[r] |-> exp_left[r] != 0)
      else log_failure($sformatf("reader %0d issued a word beyond its command", r));

    a_back_pressure : assert property (@(posedge clk_i) disable iff (!rst_ni)
      !operand_queue_ready[r] |-> !operand_issued[r])
      else log_failure($sformatf("reader %0d issued while its queue was not ready", r));

    a_read_bank : assert property (@(posedge clk_i) disable iff (!rst_ni)
      operand_issued[r] |-> vrf_req[rd_bank[r]] && !vrf[rd_bank[r]].wen &&
        vrf[rd_bank[r]].opqueue == vrf_pkg::opqueue_e'(1'(r)))
      else log_failure($sformatf("reader %0d read missing on its bank", r));

    a_read_row : assert property (@(posedge clk_i) disable iff (!rst_ni)
      operand_issued[r] |-> rd_row_seen[r] == (exp_addr[r] >> BankBits))
      else log_mismatch("vrf_o.addr", 64'($sampled(exp_addr[r]) >> BankBits),
        64'($sampled(rd_row_seen[r])));

    a_alu_first : assert property (@(posedge clk_i) disable iff (!rst_ni)
      alu_result_req && rd_active[r] && alu_bank == rd_bank[r] |-> !operand_issued[r])
      else log_failure($sformatf("reader %0d issued over an ALU write", r));

    for (genvar b = 0; b < NrBanks; b++) begin : gen_bank
      a_read_owned : assert property (@(posedge clk_i) disable iff (!rst_ni)
        vrf_req[b] && !vrf[b].wen && vrf[b].opqueue == vrf_pkg::opqueue_e'(1'(r)) |->
          operand_issued[r] && rd_bank[r] == BankBits'(b))
        else log_failure($sformatf("bank %0d read for reader %0d without an issue", b, r));
    end
  end

  a_alu_write : assert property (@(posedge clk_i) disable iff (!rst_ni)
    alu_result_req |-> alu_result_gnt && vrf_req[alu_bank] && alu_seen.wen &&
      alu_seen.be == alu_result.be && alu_seen.addr == (alu_result.addr >> BankBits))
    else log_failure("ALU write not on its bank with its row and enables");

  a_alu_data : assert property (@(posedge clk_i) disable iff (!rst_ni)
    alu_result_req |-> alu_seen.wdata == alu_result.wdata)
    else log_mismatch("vrf_o.wdata", $sampled(alu_result.wdata), $sampled(alu_seen.wdata));

  a_round_robin : assert property (@(posedge clk_i) disable iff (!rst_ni)
    contend |-> operand_issued == (rr_next[rd_bank[0]] ? 2'b10 : 2'b01))
    else log_mismatch("operand_issued_o", 64'($sampled(rr_next[rd_bank[0]]) ? 2'b10 : 2'b01),
      64'($sampled(operand_issued)));

  a_final_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ldu_result_final_gnt == ldu_wrote)
    else log_mismatch("ldu_result_final_gnt_o", 64'($sampled(ldu_wrote)),
      64'($sampled(ldu_result_final_gnt)));

  a_reset_quiet : assert property (@(posedge clk_i)
    !rst_ni |-> vrf_req == '0 && operand_issued == '0 && operand_request_ready == '0 &&
      !alu_result_gnt && !ldu_result_gnt && !ldu_result_final_gnt)
    else log_failure("outputs active during reset");

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Leaves the caller a short delay after a rising edge
  task automatic next_cycle(int unsigned n);
    repeat (n) @(posedge clk_i);
    #0.5;
  endtask

  function automatic vrf_pkg::operand_request_t random_cmd();
    vrf_pkg::operand_request_t cmd;
    cmd.addr = vrf_pkg::vaddr_t'($urandom);
    cmd.vl   = ($urandom_range(0, 7) == 0) ? '0 : vrf_pkg::vl_t'($urandom_range(1, MaxVl));
    cmd.eew  = vrf_pkg::vew_e'(2'($urandom_range(0, 3)));
    return cmd;
  endfunction

  function automatic vrf_pkg::result_t random_result();
    vrf_pkg::result_t res;
    res.addr  = vrf_pkg::vaddr_t'($urandom);
    res.wdata = {$urandom, $urandom};
    res.be    = vrf_pkg::strb_t'($urandom);
    return res;
  endfunction

  task automatic send_read(int unsigned r, vrf_pkg::operand_request_t cmd);
    operand_request[r]       = cmd;
    operand_request_valid[r] = 1'b1;
    do @(posedge clk_i); while (!operand_request_ready[r]);
    #0.5;
    operand_request_valid[r] = 1'b0;
  endtask

  task automatic send_load(vrf_pkg::result_t res);
    ldu_result     = res;
    ldu_result_req = 1'b1;
    do @(posedge clk_i); while (!ldu_result_gnt);
    #0.5;
    ldu_result_req = 1'b0;
  endtask

  task automatic run_reader(int unsigned r);
    vrf_pkg::operand_request_t cmd;
    for (int i = 0; i < NumCmds; i++) begin
      cmd = random_cmd();
      // First command of each reader is empty
      if (i == 0) begin
        cmd.vl = '0;
      end
      send_read(r, cmd);
      next_cycle($urandom_range(0, 2));
    end
  endtask

  task automatic drive_queue_ready();
    for (int i = 0; i < NumCmds * MaxVl / 2; i++) begin
      for (int r = 0; r < NrRd; r++) begin
        operand_queue_ready[r] = ($urandom_range(0, 3) != 0);
      end
      next_cycle(1);
    end
    operand_queue_ready = '1;
  endtask

  task automatic drive_alu();
    for (int i = 0; i < NumWrites * 8; i++) begin
      alu_result     = random_result();
      alu_result_req = ($urandom_range(0, 5) == 0);
      next_cycle(1);
    end
    alu_result_req = 1'b0;
  endtask

  task automatic drive_loads();
    for (int i = 0; i < NumWrites; i++) begin
      next_cycle($urandom_range(0, 3));
      send_load(random_result());
    end
  endtask

  task automatic wait_drained();
    while (exp_left[0] != 0 || exp_left[1] != 0 || ldu_pending.size() != 0) begin
      next_cycle(1);
    end
  endtask

  initial begin
    vrf_pkg::operand_request_t cmd;
    void'($urandom(32'h5837_7770));
    rst_ni                = 1'b0;
    operand_request       = '0;
    operand_request_valid = '0;
    operand_queue_ready   = '1;
    alu_result            = '0;
    alu_result_req        = 1'b0;
    ldu_result            = '0;
    ldu_result_req        = 1'b0;
    repeat (16) @(posedge clk_i);
    #0.5;
    rst_ni = 1'b1;
    next_cycle(2);

    // Mixed traffic with back-pressure and writes
    fork
      run_reader(0);
      run_reader(1);
      drive_queue_ready();
      drive_alu();
      drive_loads();
    join
    wait_drained();

    // Both readers start on one bank with no writers
    for (int k = 0; k < 6; k++) begin
      cmd.addr = vrf_pkg::vaddr_t'(12'h040 + k);
      cmd.vl   = vrf_pkg::vl_t'(8);
      cmd.eew  = vrf_pkg::EW64;
      fork
        send_read(0, cmd);
        send_read(1, cmd);
      join
      wait_drained();
    end
    next_cycle(4);

    $display("Checks done: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches + failures == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(TimeoutCycles * ClkPeriodNs);
    log_failure("watchdog expired before the test finished");
    $display("Checks done: %0d mismatches, %0d other errors", mismatches, failures);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* verilog.f */
logic/vrf_pkg.sv
logic/element_counter.sv
logic/operand_requester_fsm.sv
logic/result_stream_reg.sv
logic/bank_arbiter.sv
logic/operand_request_stage.sv
verification/operand_request_stage_tb.sv
